// File: common/csr_pkg.sv
package csr_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0] cause_t;
  typedef logic [3:0] timer_addr_t;

  localparam csr_addr_t csr_mstatus = 12'h300;
  localparam csr_addr_t csr_misa = 12'h301;
  localparam csr_addr_t csr_medeleg = 12'h302;
  localparam csr_addr_t csr_mideleg = 12'h303;
  localparam csr_addr_t csr_mie = 12'h304;
  localparam csr_addr_t csr_mtvec = 12'h305;
  localparam csr_addr_t csr_mcounteren = 12'h306;
  localparam csr_addr_t csr_mscratch = 12'h340;
  localparam csr_addr_t csr_mepc = 12'h341;
  localparam csr_addr_t csr_mcause = 12'h342;
  localparam csr_addr_t csr_mtval = 12'h343;
  localparam csr_addr_t csr_mip = 12'h344;
  localparam csr_addr_t csr_mcycle = 12'hB00;
  localparam csr_addr_t csr_minstret = 12'hB02;
  localparam csr_addr_t csr_mcycleh = 12'hB80;
  localparam csr_addr_t csr_minstreth = 12'hB82;

  localparam cause_t interrupt_mach_timer = 4'd7;

  localparam int mstatus_mie = 3;
  localparam int mstatus_mpie = 7;
  localparam int mie_mtie = 7;
  localparam logic [1:0] mtvec_vectored = 2'b01;

  localparam xlen_t mstatus_mask = 32'h807F_F9BB; // SD, 22:11, 8:7, 5:3 and 1:0.
  localparam xlen_t misa_mask = 32'hC3FF_FFFF;
  localparam xlen_t mie_mask = 32'h0000_0BBB;

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef struct packed {
    logic crden;
    csr_addr_t craddr;
    logic cwren;
    csr_addr_t cwaddr;
    xlen_t cdata;
    logic valid; // One instruction retires this cycle.
    logic exception;
    xlen_t epc;
    xlen_t etval;
    cause_t ecause;
    logic mret;
  } csr_in_type;

  typedef struct packed {
    xlen_t cdata;
    logic exception;
    logic mret;
    xlen_t mepc;
    xlen_t mtvec; // Trap target, already vectored.
  } csr_out_type;

  typedef struct packed {
    xlen_t mstatus;
    xlen_t misa;
    xlen_t medeleg;
    xlen_t mideleg;
    xlen_t mie;
    xlen_t mtvec;
    xlen_t mcounteren;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
    logic [63:0] mcycle;
    logic [63:0] minstret;
  } csr_machine_reg_type;

  localparam csr_machine_reg_type init_csr_machine_reg = '{
    misa: 32'h4000_0100, // MXL of 1 with the I extension.
    mtvec: 32'h0000_0000,
    default: '0
  };

  typedef struct packed {
    logic awvalid;
    timer_addr_t awaddr;
    logic wvalid;
    xlen_t wdata;
    logic [3:0] wstrb;
    logic bready;
    logic arvalid;
    timer_addr_t araddr;
    logic rready;
  } axil_req_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    xlen_t rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic wr;
    logic rd;
    timer_addr_t addr;
    xlen_t wdata;
    logic [3:0] wstrb;
  } reg_req_t;

endpackage

// File: csr/csr.sv
`timescale 1ns/1ps

module csr (
  input logic clk,
  input logic rst,
  input csr_pkg::csr_in_type csr_in,
  input logic timer_irpt,
  output csr_pkg::csr_out_type csr_out
);
  import csr_pkg::*;

  csr_machine_reg_type machine_reg;
  logic trap_q;
  logic mret_q;
  logic irq_take;
  logic trap_take;
  xlen_t trap_cause;
  xlen_t mip_live;
  xlen_t trap_base;
  xlen_t vec_offset;

  always_comb begin
    mip_live = '0;
    mip_live[mie_mtie] = timer_irpt; // Pending bit follows the timer line directly.

    irq_take = timer_irpt & machine_reg.mstatus[mstatus_mie] &
               machine_reg.mie[mie_mtie] & ~csr_in.exception;
    trap_take = csr_in.exception | irq_take;

    if (csr_in.exception) begin
      trap_cause = {28'h0, csr_in.ecause};
    end else begin
      trap_cause = {1'b1, 27'h0, interrupt_mach_timer};
    end
  end

  always_comb begin
    if (csr_in.crden) begin
      case (csr_in.craddr)
        csr_mstatus: csr_out.cdata = machine_reg.mstatus & mstatus_mask;
        csr_misa: csr_out.cdata = machine_reg.misa & misa_mask;
        csr_medeleg: csr_out.cdata = machine_reg.medeleg;
        csr_mideleg: csr_out.cdata = machine_reg.mideleg;
        csr_mie: csr_out.cdata = machine_reg.mie & mie_mask;
        csr_mtvec: csr_out.cdata = machine_reg.mtvec;
        csr_mcounteren: csr_out.cdata = machine_reg.mcounteren;
        csr_mscratch: csr_out.cdata = machine_reg.mscratch;
        csr_mepc: csr_out.cdata = machine_reg.mepc;
        csr_mcause: csr_out.cdata = machine_reg.mcause;
        csr_mtval: csr_out.cdata = machine_reg.mtval;
        csr_mip: csr_out.cdata = mip_live & mie_mask;
        csr_mcycle: csr_out.cdata = machine_reg.mcycle[31:0];
        csr_mcycleh: csr_out.cdata = machine_reg.mcycle[63:32];
        csr_minstret: csr_out.cdata = machine_reg.minstret[31:0];
        csr_minstreth: csr_out.cdata = machine_reg.minstret[63:32];
        default: csr_out.cdata = '0;
      endcase
    end else begin
      csr_out.cdata = '0;
    end
  end

  // Trap target. Only interrupts are spread over the vector table.
  always_comb begin
    trap_base = {machine_reg.mtvec[31:2], 2'b00};
    vec_offset = {26'h0, machine_reg.mcause[3:0], 2'b00};
    if (machine_reg.mtvec[1:0] == mtvec_vectored && machine_reg.mcause[31]) begin
      csr_out.mtvec = trap_base + vec_offset;
    end else begin
      csr_out.mtvec = trap_base;
    end
    csr_out.mepc = machine_reg.mepc;
    csr_out.exception = trap_q;
    csr_out.mret = mret_q;
  end

  // Later assignments in this block take priority over earlier ones.
  always_ff @(posedge clk) begin
    if (!rst) begin
      machine_reg <= init_csr_machine_reg;
      trap_q <= 1'b0;
      mret_q <= 1'b0;
    end else begin
      machine_reg.mcycle <= machine_reg.mcycle + 64'd1;
      if (csr_in.valid) begin
        machine_reg.minstret <= machine_reg.minstret + 64'd1;
      end

      if (csr_in.cwren) begin
        case (csr_in.cwaddr)
          csr_mstatus: machine_reg.mstatus <= csr_in.cdata & mstatus_mask;
          csr_misa: machine_reg.misa <= csr_in.cdata & misa_mask;
          csr_medeleg: machine_reg.medeleg <= csr_in.cdata;
          csr_mideleg: machine_reg.mideleg <= csr_in.cdata;
          csr_mie: machine_reg.mie <= csr_in.cdata & mie_mask;
          csr_mtvec: machine_reg.mtvec <= csr_in.cdata;
          csr_mcounteren: machine_reg.mcounteren <= csr_in.cdata;
          csr_mscratch: machine_reg.mscratch <= csr_in.cdata;
          csr_mepc: machine_reg.mepc <= csr_in.cdata;
          csr_mcause: machine_reg.mcause <= csr_in.cdata;
          csr_mtval: machine_reg.mtval <= csr_in.cdata;
          csr_mcycle: machine_reg.mcycle[31:0] <= csr_in.cdata;
          csr_mcycleh: machine_reg.mcycle[63:32] <= csr_in.cdata;
          csr_minstret: machine_reg.minstret[31:0] <= csr_in.cdata;
          csr_minstreth: machine_reg.minstret[63:32] <= csr_in.cdata;
          default: ; // mip is read only here.
        endcase
      end

      if (csr_in.mret) begin
        machine_reg.mstatus[mstatus_mie] <= machine_reg.mstatus[mstatus_mpie];
        machine_reg.mstatus[mstatus_mpie] <= 1'b0;
      end

      if (trap_take) begin
        machine_reg.mstatus[mstatus_mpie] <= machine_reg.mstatus[mstatus_mie];
        machine_reg.mstatus[mstatus_mie] <= 1'b0; // Masks a second interrupt until mret.
        machine_reg.mepc <= csr_in.epc;
        machine_reg.mtval <= csr_in.etval;
        machine_reg.mcause <= trap_cause;
      end

      trap_q <= trap_take;
      mret_q <= csr_in.mret;
    end
  end

endmodule

// File: timer/machine_timer.sv
`timescale 1ns/1ps

module machine_timer #(
  parameter int TIMER_DIV = 1
) (
  input logic clk,
  input logic rst,
  input csr_pkg::reg_req_t reg_req,
  output csr_pkg::xlen_t rdata,
  output logic err,
  output logic timer_irpt
);
  import csr_pkg::*;

  localparam int div_w = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(TIMER_DIV - 1);

  localparam timer_addr_t off_mtime_lo = 4'h0;
  localparam timer_addr_t off_mtime_hi = 4'h4;
  localparam timer_addr_t off_cmp_lo = 4'h8;
  localparam timer_addr_t off_cmp_hi = 4'hC;

  logic [div_w-1:0] prescale;
  logic tick;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic mapped;
  xlen_t read_word;

  function automatic xlen_t byte_merge(xlen_t old_word, xlen_t new_word, logic [3:0] strb);
    xlen_t merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  assign tick = (prescale == div_last);
  assign timer_irpt = (mtime >= mtimecmp); // Unsigned compare over the full 64 bits.

  always_ff @(posedge clk) begin
    if (!rst) begin
      prescale <= '0;
      mtime <= '0;
      mtimecmp <= '1;
    end else begin
      if (tick) begin
        prescale <= '0;
        mtime <= mtime + 64'd1;
      end else begin
        prescale <= prescale + 1'b1;
      end

      // A register write overrides the tick for the half it touches.
      if (reg_req.wr) begin
        case (reg_req.addr)
          off_mtime_lo: mtime[31:0] <= byte_merge(mtime[31:0], reg_req.wdata, reg_req.wstrb);
          off_mtime_hi: mtime[63:32] <= byte_merge(mtime[63:32], reg_req.wdata, reg_req.wstrb);
          off_cmp_lo: begin
            mtimecmp[31:0] <= byte_merge(mtimecmp[31:0], reg_req.wdata, reg_req.wstrb);
          end
          off_cmp_hi: begin
            mtimecmp[63:32] <= byte_merge(mtimecmp[63:32], reg_req.wdata, reg_req.wstrb);
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    mapped = 1'b1;
    case (reg_req.addr)
      off_mtime_lo: read_word = mtime[31:0];
      off_mtime_hi: read_word = mtime[63:32];
      off_cmp_lo: read_word = mtimecmp[31:0];
      off_cmp_hi: read_word = mtimecmp[63:32];
      default: begin
        read_word = '0;
        mapped = 1'b0;
      end
    endcase

    rdata = reg_req.rd ? read_word : '0;
    err = (reg_req.rd | reg_req.wr) & ~mapped;
  end

endmodule

// File: logic/axil_reg_port.sv
`timescale 1ns/1ps

module axil_reg_port (
  input logic clk,
  input logic rst,
  input csr_pkg::axil_req_t axil_req,
  output csr_pkg::axil_rsp_t axil_rsp,
  output csr_pkg::reg_req_t reg_req,
  input csr_pkg::xlen_t rdata,
  input logic err
);
  import csr_pkg::*;

  logic aw_full;
  logic w_full;
  logic bvalid;
  logic rvalid;
  timer_addr_t aw_addr;
  xlen_t w_data;
  logic [3:0] w_strb;
  logic [1:0] bresp;
  logic [1:0] rresp;
  xlen_t rdata_q;
  logic awready;
  logic wready;
  logic arready;
  logic wr_fire;

  assign wr_fire = aw_full & w_full;
  assign awready = ~aw_full & ~bvalid;
  assign wready = ~w_full & ~bvalid;
  assign arready = ~rvalid & ~wr_fire; // The write strobe owns the shared address this cycle.

  assign axil_rsp = '{
    awready: awready,
    wready: wready,
    bvalid: bvalid,
    bresp: bresp,
    arready: arready,
    rvalid: rvalid,
    rdata: rdata_q,
    rresp: rresp
  };

  assign reg_req.wr = wr_fire;
  assign reg_req.rd = axil_req.arvalid & arready;
  assign reg_req.addr = wr_fire ? aw_addr : axil_req.araddr;
  assign reg_req.wdata = w_data;
  assign reg_req.wstrb = w_strb;

  always_ff @(posedge clk) begin
    if (!rst) begin
      aw_full <= 1'b0;
      w_full <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_fire) begin
        aw_full <= 1'b0;
        w_full <= 1'b0;
        bvalid <= 1'b1;
      end else begin
        if (axil_req.awvalid && awready) aw_full <= 1'b1;
        if (axil_req.wvalid && wready) w_full <= 1'b1;
        if (bvalid && axil_req.bready) bvalid <= 1'b0;
      end

      if (reg_req.rd) begin
        rvalid <= 1'b1;
      end else if (rvalid && axil_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (axil_req.awvalid && awready) aw_addr <= axil_req.awaddr;
    if (axil_req.wvalid && wready) begin
      w_data <= axil_req.wdata;
      w_strb <= axil_req.wstrb;
    end
    if (wr_fire) bresp <= err ? resp_slverr : resp_okay;
    if (reg_req.rd) begin
      rdata_q <= rdata; // Frozen until the master takes it.
      rresp <= err ? resp_slverr : resp_okay;
    end
  end

endmodule

// File: logic/machine_mode_top.sv
`timescale 1ns/1ps

module machine_mode_top #(
  parameter int TIMER_DIV = 1
) (
  input logic clk,
  input logic rst,
  input csr_pkg::csr_in_type csr_in,
  output csr_pkg::csr_out_type csr_out,
  input csr_pkg::axil_req_t axil_req,
  output csr_pkg::axil_rsp_t axil_rsp,
  output logic timer_irpt
);
  import csr_pkg::*;

  reg_req_t reg_req;
  xlen_t timer_rdata;
  logic timer_err;

  csr u_csr (
    .clk(clk),
    .rst(rst),
    .csr_in(csr_in),
    .timer_irpt(timer_irpt),
    .csr_out(csr_out)
  );

  machine_timer #(
    .TIMER_DIV(TIMER_DIV)
  ) u_timer (
    .clk(clk),
    .rst(rst),
    .reg_req(reg_req),
    .rdata(timer_rdata),
    .err(timer_err),
    .timer_irpt(timer_irpt)
  );

  axil_reg_port u_port (
    .clk(clk),
    .rst(rst),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .reg_req(reg_req),
    .rdata(timer_rdata),
    .err(timer_err)
  );

endmodule

// File: verification/machine_mode_model.svh
`ifndef MACHINE_MODE_MODEL_SVH
`define MACHINE_MODE_MODEL_SVH

csr_machine_reg_type model_reg;
logic [63:0] model_cmp;

function automatic void model_reset();
  model_reg = init_csr_machine_reg;
  model_cmp = '1;
endfunction

function automatic xlen_t merge_bytes(xlen_t old_word, xlen_t new_word, logic [3:0] strb);
  xlen_t result;
  result = old_word;
  for (int b = 0; b < 4; b++) begin
    if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
  end
  return result;
endfunction

function automatic void model_csr_write(csr_addr_t addr, xlen_t data);
  case (addr)
    csr_mstatus: model_reg.mstatus = data & mstatus_mask;
    csr_misa: model_reg.misa = data & misa_mask;
    csr_medeleg: model_reg.medeleg = data;
    csr_mideleg: model_reg.mideleg = data;
    csr_mie: model_reg.mie = data & mie_mask;
    csr_mtvec: model_reg.mtvec = data;
    csr_mcounteren: model_reg.mcounteren = data;
    csr_mscratch: model_reg.mscratch = data;
    csr_mepc: model_reg.mepc = data;
    csr_mcause: model_reg.mcause = data;
    csr_mtval: model_reg.mtval = data;
    csr_minstret: model_reg.minstret[31:0] = data;
    csr_minstreth: model_reg.minstret[63:32] = data;
    default: ; // Unknown addresses and mip keep no state.
  endcase
endfunction

function automatic xlen_t model_csr_read(csr_addr_t addr, logic irpt);
  case (addr)
    csr_mstatus: return model_reg.mstatus & mstatus_mask;
    csr_misa: return model_reg.misa & misa_mask;
    csr_medeleg: return model_reg.medeleg;
    csr_mideleg: return model_reg.mideleg;
    csr_mie: return model_reg.mie & mie_mask;
    csr_mtvec: return model_reg.mtvec;
    csr_mcounteren: return model_reg.mcounteren;
    csr_mscratch: return model_reg.mscratch;
    csr_mepc: return model_reg.mepc;
    csr_mcause: return model_reg.mcause;
    csr_mtval: return model_reg.mtval;
    csr_mip: return {24'h0, irpt, 7'h0} & mie_mask;
    csr_minstret: return model_reg.minstret[31:0];
    csr_minstreth: return model_reg.minstret[63:32];
    default: return '0;
  endcase
endfunction

function automatic void model_trap(xlen_t epc, xlen_t tval, xlen_t cause);
  model_reg.mstatus[mstatus_mpie] = model_reg.mstatus[mstatus_mie];
  model_reg.mstatus[mstatus_mie] = 1'b0;
  model_reg.mepc = epc;
  model_reg.mtval = tval;
  model_reg.mcause = cause;
endfunction

function automatic void model_mret();
  model_reg.mstatus[mstatus_mie] = model_reg.mstatus[mstatus_mpie];
  model_reg.mstatus[mstatus_mpie] = 1'b0;
endfunction

// Interrupts land at base plus four times the cause in vectored mode.
function automatic xlen_t model_trap_target();
  xlen_t base;
  base = model_reg.mtvec & 32'hFFFF_FFFC;
  if (model_reg.mtvec[1:0] == 2'b01 && model_reg.mcause[31]) begin
    return base + 32'(model_reg.mcause[3:0]) * 32'd4;
  end
  return base;
endfunction

`endif

// File: verification/machine_mode_tb.sv
`timescale 1ns/1ps

module machine_mode_tb;
  import csr_pkg::*;

  localparam int t1_len = 200;
  localparam int t2_len = 450;
  localparam int t3_len = 250;
  localparam int t4_len = 150;
  localparam int t5_len = 1500;
  localparam int t6_len = 300;
  localparam int timeout_limit = 2 * (t1_len + t2_len + t3_len + t4_len + t5_len + t6_len) + 200;

  logic clk = 1'b0;
  logic rst;
  csr_in_type csr_in;
  csr_out_type csr_out;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic timer_irpt;

  logic [31:0] lcg_state = 32'd15433;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int cycle_count = 0;

  `include "machine_mode_model.svh"

  machine_mode_top #(
    .TIMER_DIV(1)
  ) dut (
    .clk(clk),
    .rst(rst),
    .csr_in(csr_in),
    .csr_out(csr_out),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .timer_irpt(timer_irpt)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Run stopped after %0d cycles, the DUT stopped responding.", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]}; // Upper bits are the better ones.
  endfunction

  task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
  endtask

  task automatic write_csr(input csr_addr_t addr, input xlen_t data);
    @(posedge clk);
    csr_in.cwren <= 1'b1;
    csr_in.cwaddr <= addr;
    csr_in.cdata <= data;
    @(posedge clk);
    csr_in.cwren <= 1'b0;
    model_csr_write(addr, data);
  endtask

  task automatic read_csr(input csr_addr_t addr, output xlen_t data);
    @(posedge clk);
    csr_in.crden <= 1'b1;
    csr_in.craddr <= addr;
    @(negedge clk);
    data = csr_out.cdata;
  endtask

  task automatic expect_csr(input string name, input csr_addr_t addr, input logic irpt);
    xlen_t got;
    read_csr(addr, got);
    check_data(name, model_csr_read(addr, irpt), got);
  endtask

  task automatic axi_write(input timer_addr_t addr, input xlen_t data, input logic [3:0] strb,
                           output logic [1:0] resp);
    logic aw_done;
    logic w_done;
    logic [31:0] r;
    int order;
    aw_done = 1'b0;
    w_done = 1'b0;
    r = lcg_next();
    order = int'(r % 3); // Address first, data first, or both together.
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      axil_req.awaddr <= addr;
      axil_req.wdata <= data;
      axil_req.wstrb <= strb;
      axil_req.awvalid <= !aw_done && (order != 1 || w_done);
      axil_req.wvalid <= !w_done && (order != 0 || aw_done);
      @(negedge clk);
      if (axil_req.awvalid && axil_rsp.awready) aw_done = 1'b1;
      if (axil_req.wvalid && axil_rsp.wready) w_done = 1'b1;
    end
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid <= 1'b0;
    forever begin
      r = lcg_next();
      axil_req.bready <= r[0];
      @(negedge clk);
      if (axil_rsp.bvalid && axil_req.bready) break;
      @(posedge clk);
    end
    resp = axil_rsp.bresp;
    @(posedge clk);
    axil_req.bready <= 1'b0;
    @(negedge clk);
    check_flag("axil_rsp.bvalid after response", 1'b0, axil_rsp.bvalid);
  endtask

  task automatic axi_read(input timer_addr_t addr, output xlen_t data, output logic [1:0] resp);
    logic [31:0] r;
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr <= addr;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    forever begin
      r = lcg_next();
      axil_req.rready <= r[0];
      @(negedge clk);
      if (axil_rsp.rvalid && axil_req.rready) break;
      @(posedge clk);
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);
    axil_req.rready <= 1'b0;
    @(negedge clk);
    check_flag("axil_rsp.rvalid after response", 1'b0, axil_rsp.rvalid);
  endtask

  // Drives one cycle of a pulse request and checks the one-cycle response pulse.
  task automatic pulse_request(input logic is_mret);
    @(posedge clk);
    if (is_mret) csr_in.mret <= 1'b1;
    else csr_in.exception <= 1'b1;
    @(negedge clk);
    check_flag("pulse before edge", 1'b0, is_mret ? csr_out.mret : csr_out.exception);
    @(posedge clk);
    csr_in.mret <= 1'b0;
    csr_in.exception <= 1'b0;
    @(negedge clk);
    check_flag("pulse after edge", 1'b1, is_mret ? csr_out.mret : csr_out.exception);
    @(negedge clk);
    check_flag("pulse one cycle later", 1'b0, is_mret ? csr_out.mret : csr_out.exception);
  endtask

  initial begin
    csr_addr_t rw_addrs[14];
    csr_addr_t addr;
    logic [31:0] r;
    logic [31:0] v;
    xlen_t got;
    xlen_t hi0;
    xlen_t base;
    timer_addr_t off;
    logic [1:0] resp;
    logic seen_irpt;
    logic seen_pulse;
    int k;
    int retired;
    int errors_before;

    rw_addrs = '{csr_mstatus, csr_misa, csr_medeleg, csr_mideleg, csr_mie, csr_mtvec,
                 csr_mcounteren, csr_mscratch, csr_mepc, csr_mcause, csr_mtval, csr_mip,
                 csr_minstret, csr_minstreth};
    csr_in = '0;
    axil_req = '0;
    rst = 1'b0;
    model_reset();
    repeat (16) @(posedge clk);
    rst <= 1'b1;

    errors_before = error_count;
    for (int i = 0; i < 60; i++) begin
      r = lcg_next();
      addr = (r[7:4] == 4'h0) ? 12'h7C0 + 12'(r[3:0]) : rw_addrs[r % 14]; // Some unknown.
      write_csr(addr, lcg_next());
      expect_csr("csr_out.cdata", addr, 1'b0);
    end
    report_test("csr_read_write", errors_before);

    errors_before = error_count;
    for (int i = 0; i < 8; i++) begin
      v = lcg_next() & 32'h7FFF_FFFF;
      r = lcg_next();
      k = int'(r % 16);
      write_csr(csr_mcycleh, '0);
      write_csr(csr_mcycle, v);
      repeat (k) @(posedge clk);
      read_csr(csr_mcycle, got);
      check_data("mcycle", v + 32'(k) + 32'd1, got); // The read lands one edge later.

      write_csr(csr_minstreth, '0);
      write_csr(csr_minstret, v);
      retired = 0;
      for (int j = 0; j < 20; j++) begin
        r = lcg_next();
        @(posedge clk);
        csr_in.valid <= r[0];
        if (r[0]) retired++;
      end
      @(posedge clk);
      csr_in.valid <= 1'b0;
      read_csr(csr_minstret, got);
      check_data("minstret", v + 32'(retired), got);

      @(posedge clk);
      csr_in.cwren <= 1'b1;
      csr_in.cwaddr <= csr_minstret;
      csr_in.cdata <= ~v;
      csr_in.valid <= 1'b1;
      @(posedge clk);
      csr_in.cwren <= 1'b0;
      csr_in.valid <= 1'b0;
      model_csr_write(csr_minstret, ~v);
      expect_csr("minstret after write and retire", csr_minstret, 1'b0);
    end
    report_test("counters", errors_before);

    errors_before = error_count;
    for (int i = 0; i < 10; i++) begin
      r = lcg_next();
      write_csr(csr_mtvec, (lcg_next() & 32'hFFFF_FFFC) | {31'h0, r[0]});
      write_csr(csr_mstatus, {24'h0, r[8], 3'b000, r[4], 3'b000});
      v = lcg_next();
      @(posedge clk);
      csr_in.epc <= v;
      csr_in.etval <= ~v;
      csr_in.ecause <= r[15:12];
      model_trap(v, ~v, {28'h0, r[15:12]});
      pulse_request(1'b0);
      check_data("csr_out.mepc", model_reg.mepc, csr_out.mepc);
      check_data("csr_out.mtvec", model_trap_target(), csr_out.mtvec);
      expect_csr("mepc", csr_mepc, 1'b0);
      expect_csr("mtval", csr_mtval, 1'b0);
      expect_csr("mcause", csr_mcause, 1'b0);
      expect_csr("mstatus", csr_mstatus, 1'b0);
    end
    report_test("exceptions", errors_before);

    errors_before = error_count;
    for (int i = 0; i < 10; i++) begin
      r = lcg_next();
      write_csr(csr_mstatus, {24'h0, r[1], 3'b000, r[0], 3'b000});
      pulse_request(1'b1);
      model_mret();
      expect_csr("mstatus after mret", csr_mstatus, 1'b0);
    end
    report_test("mret", errors_before);

    errors_before = error_count;
    write_csr(csr_mstatus, '0);
    for (int i = 0; i < 40; i++) begin
      r = lcg_next();
      if (r[2:0] < 3'd5) begin
        off = r[3] ? 4'hC : 4'h8;
        v = lcg_next();
        axi_write(off, v, r[7:4], resp);
        check_resp("axil_rsp.bresp", resp_okay, resp);
        if (off == 4'h8) model_cmp[31:0] = merge_bytes(model_cmp[31:0], v, r[7:4]);
        else model_cmp[63:32] = merge_bytes(model_cmp[63:32], v, r[7:4]);
        axi_read(off, got, resp);
        check_resp("axil_rsp.rresp", resp_okay, resp);
        check_data("mtimecmp", off == 4'h8 ? model_cmp[31:0] : model_cmp[63:32], got);
      end else if (r[2:0] == 3'd5) begin
        off = r[11:8];
        if (off[1:0] == 2'b00) off[0] = 1'b1;
        axi_write(off, lcg_next(), 4'hF, resp);
        check_resp("axil_rsp.bresp unmapped", resp_slverr, resp);
        axi_read(off, got, resp);
        check_resp("axil_rsp.rresp unmapped", resp_slverr, resp);
        check_data("axil_rsp.rdata unmapped", '0, got);
      end else begin
        v = lcg_next() & 32'h7FFF_FFFF;
        axi_write(4'h4, v, 4'hF, resp);
        check_resp("axil_rsp.bresp mtime", resp_okay, resp);
        axi_write(4'h0, 32'hFFFF_FFFC, 4'hF, resp); // The low word wraps within a few ticks.
        check_resp("axil_rsp.bresp mtime", resp_okay, resp);
        axi_read(4'h4, hi0, resp);
        check_resp("axil_rsp.rresp mtime", resp_okay, resp);
        repeat (int'(r[7:4])) @(posedge clk);
        axi_read(4'h4, got, resp);
        check_resp("axil_rsp.rresp mtime", resp_okay, resp);
        check_flag("mtime high not decreasing", 1'b1, got >= hi0);
        check_data("mtime high after carry", v + 32'd1, got);
      end
    end
    report_test("timer_axi", errors_before);

    errors_before = error_count;
    base = lcg_next() & 32'hFFFF_FF00;
    write_csr(csr_mtvec, base | 32'h1);
    write_csr(csr_mie, 32'h80);
    @(posedge clk);
    csr_in.epc <= '0;
    csr_in.etval <= '0;
    axi_read(4'h4, hi0, resp);
    axi_write(4'hC, hi0, 4'hF, resp);
    axi_read(4'h0, v, resp);
    axi_write(4'h8, v + 32'd60, 4'hF, resp); // A few dozen ticks ahead of mtime.
    write_csr(csr_mstatus, 32'h8);
    @(negedge clk);
    check_flag("timer_irpt before compare", 1'b0, timer_irpt);
    seen_irpt = 1'b0;
    seen_pulse = 1'b0;
    for (int i = 0; i < 150 && !seen_pulse; i++) begin
      @(negedge clk);
      if (timer_irpt) seen_irpt = 1'b1;
      if (csr_out.exception) seen_pulse = 1'b1;
    end
    check_flag("timer_irpt rose", 1'b1, seen_irpt);
    check_flag("interrupt pulse", 1'b1, seen_pulse);
    model_trap('0, '0, 32'h8000_0007);
    expect_csr("mip", csr_mip, 1'b1);
    expect_csr("mcause", csr_mcause, 1'b1);
    expect_csr("mstatus", csr_mstatus, 1'b1);
    check_data("csr_out.mtvec", base + 32'd28, csr_out.mtvec);
    seen_pulse = 1'b0;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (csr_out.exception) seen_pulse = 1'b1;
    end
    check_flag("second pulse before mret", 1'b0, seen_pulse);
    pulse_request(1'b1);
    if (csr_out.exception) seen_pulse = 1'b1; // The interrupt is taken on the edge after mret.
    for (int i = 0; i < 10 && !seen_pulse; i++) begin
      @(negedge clk);
      if (csr_out.exception) seen_pulse = 1'b1;
    end
    check_flag("interrupt again after mret", 1'b1, seen_pulse);
    report_test("timer_interrupt", errors_before);

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+verification
common/csr_pkg.sv
csr/csr.sv
timer/machine_timer.sv
logic/axil_reg_port.sv
logic/machine_mode_top.sv
verification/machine_mode_tb.sv

// File: Makefile
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f flist.f --top-module machine_mode_tb -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/Vmachine_mode_tb > $(LOG)
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
